/* filelist.f */
+incdir+src
src/hypot_pkg.sv
src/step_counter.sv
src/square_accum.sv
src/isqrt_unit.sv
src/hypot_fsm.sv
src/hypot_top.sv
test/hypot_tb.sv

/* src/hypot_consts.svh */
`ifndef HYPOT_CONSTS_SVH
`define HYPOT_CONSTS_SVH

// Operand and result width
`define HYPOT_IN_W 8

// x^2 + y^2 for two 8-bit operands
`define HYPOT_SUM_W 17

`define HYPOT_SQ_STEPS 8   // One step per multiplier bit
`define HYPOT_ROOT_STEPS 9 // One step per root bit, covers the 17-bit radicand

// Edges from the accepting edge to the edge that raises done
`define HYPOT_LATENCY 28

`endif

/* src/hypot_fsm.sv */
`default_nettype none
`timescale 1ns/1ns

module hypot_fsm (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  logic                  last_step,
    output hypot_pkg::hypot_state_e state,
    output logic                  cnt_load,
    output hypot_pkg::sq_op_e     sq_op,
    output hypot_pkg::rt_op_e     rt_op,
    output logic                  busy,
    output logic                  done
);

    hypot_pkg::hypot_state_e state_nxt;

    // Next state and Mealy opcodes
    always_comb begin
        state_nxt = state;
        cnt_load  = 1'b0;
        sq_op     = hypot_pkg::SQ_HOLD;
        rt_op     = hypot_pkg::RT_HOLD;
        case (state)
            hypot_pkg::ST_IDLE: begin
                if (start) begin // Only honoured here, so a strobe while busy is dropped
                    sq_op     = hypot_pkg::SQ_START_X;
                    cnt_load  = 1'b1;
                    state_nxt = hypot_pkg::ST_SQ_X;
                end
            end
            hypot_pkg::ST_SQ_X: begin
                sq_op = hypot_pkg::SQ_STEP;
                if (last_step) state_nxt = hypot_pkg::ST_LOAD_Y;
            end
            hypot_pkg::ST_LOAD_Y: begin
                sq_op     = hypot_pkg::SQ_START_Y;
                cnt_load  = 1'b1;
                state_nxt = hypot_pkg::ST_SQ_Y;
            end
            hypot_pkg::ST_SQ_Y: begin
                sq_op = hypot_pkg::SQ_STEP;
                if (last_step) state_nxt = hypot_pkg::ST_LOAD_ROOT;
            end
            hypot_pkg::ST_LOAD_ROOT: begin
                rt_op     = hypot_pkg::RT_LOAD; // Sum is final by now
                cnt_load  = 1'b1;
                state_nxt = hypot_pkg::ST_ROOT;
            end
            hypot_pkg::ST_ROOT: begin
                rt_op = hypot_pkg::RT_STEP;
                if (last_step) state_nxt = hypot_pkg::ST_FINISH;
            end
            hypot_pkg::ST_FINISH: begin
                rt_op     = hypot_pkg::RT_FINISH;
                state_nxt = hypot_pkg::ST_IDLE;
            end
            default: state_nxt = hypot_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= hypot_pkg::ST_IDLE;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            state <= state_nxt;
            busy  <= (state_nxt != hypot_pkg::ST_IDLE);
            done  <= (state == hypot_pkg::ST_FINISH); // Single cycle, FINISH lasts one cycle
        end
    end

endmodule

`default_nettype wire

/* src/hypot_pkg.sv */
`default_nettype none

package hypot_pkg;

    // Controller phases
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_SQ_X      = 3'd1,
        ST_LOAD_Y    = 3'd2,
        ST_SQ_Y      = 3'd3,
        ST_LOAD_ROOT = 3'd4,
        ST_ROOT      = 3'd5,
        ST_FINISH    = 3'd6
    } hypot_state_e;

    // Squarer commands
    typedef enum logic [1:0] {
        SQ_HOLD    = 2'd0,
        SQ_START_X = 2'd1,
        SQ_START_Y = 2'd2,
        SQ_STEP    = 2'd3
    } sq_op_e;

    // Square root commands
    typedef enum logic [1:0] {
        RT_HOLD   = 2'd0,
        RT_LOAD   = 2'd1,
        RT_STEP   = 2'd2,
        RT_FINISH = 2'd3
    } rt_op_e;

endpackage

`default_nettype wire

/* src/hypot_top.sv */
`default_nettype none
`timescale 1ns/1ns
`include "hypot_consts.svh"

module hypot_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic [`HYPOT_IN_W-1:0] x,
    input  logic [`HYPOT_IN_W-1:0] y,
    output logic [`HYPOT_IN_W-1:0] result,
    output logic                   busy,
    output logic                   done
);

    hypot_pkg::hypot_state_e  state;
    hypot_pkg::sq_op_e        sq_op;
    hypot_pkg::rt_op_e        rt_op;
    logic                     cnt_load;
    logic                     last_step;
    logic [`HYPOT_SUM_W-1:0]  sum;     // x^2 + y^2

    hypot_fsm fsm_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .last_step (last_step),
        .state     (state),
        .cnt_load  (cnt_load),
        .sq_op     (sq_op),
        .rt_op     (rt_op),
        .busy      (busy),
        .done      (done)
    );

    // Phase length follows the state
    step_counter counter_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .state     (state),
        .cnt_load  (cnt_load),
        .last_step (last_step)
    );

    square_accum squarer_i (
        .clk   (clk),
        .rst_n (rst_n),
        .x     (x),
        .y     (y),
        .sq_op (sq_op),
        .sum   (sum)
    );

    isqrt_unit root_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .sum    (sum),
        .rt_op  (rt_op),
        .result (result)
    );

endmodule

`default_nettype wire

/* src/isqrt_unit.sv */
`default_nettype none
`timescale 1ns/1ns
`include "hypot_consts.svh"

module isqrt_unit (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`HYPOT_SUM_W-1:0] sum,
    input  hypot_pkg::rt_op_e       rt_op,
    output logic [`HYPOT_IN_W-1:0]  result
);

    localparam int IN_W   = `HYPOT_IN_W;
    localparam int SUM_W  = `HYPOT_SUM_W;
    localparam int ROOT_W = `HYPOT_ROOT_STEPS;
    localparam int RAD_W  = 2 * ROOT_W;  // Whole bit pairs
    localparam int REM_W  = ROOT_W + 3;  // Shifted remainder plus headroom

    logic [RAD_W-1:0]  rad;
    logic [REM_W-1:0]  rem;
    logic [ROOT_W-1:0] root;

    logic [REM_W-1:0]  rem_sh;
    logic [REM_W-1:0]  trial;
    logic              fits;

    // Bring down the next pair and form 4*root + 1
    assign rem_sh = {rem[REM_W-3:0], rad[RAD_W-1 -: 2]};
    assign trial  = {{(REM_W-ROOT_W-2){1'b0}}, root, 2'b01};
    assign fits   = (rem_sh >= trial);

    always_ff @(posedge clk) begin
        case (rt_op)
            hypot_pkg::RT_LOAD: begin
                rad  <= {{(RAD_W-SUM_W){1'b0}}, sum};
                rem  <= '0;
                root <= '0;
            end
            hypot_pkg::RT_STEP: begin
                rad <= {rad[RAD_W-3:0], 2'b00};
                if (fits) begin
                    rem  <= rem_sh - trial;
                    root <= {root[ROOT_W-2:0], 1'b1};
                end else begin
                    rem  <= rem_sh; // Restore
                    root <= {root[ROOT_W-2:0], 1'b0};
                end
            end
            default: begin
                rad  <= rad;
                rem  <= rem;
                root <= root;
            end
        endcase
    end

    // Output register, clamps roots above 255
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (rt_op == hypot_pkg::RT_FINISH) begin
            if (root[ROOT_W-1:IN_W] != '0) result <= '1;
            else                           result <= root[IN_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* src/square_accum.sv */
`default_nettype none
`timescale 1ns/1ns
`include "hypot_consts.svh"

module square_accum (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`HYPOT_IN_W-1:0]  x,
    input  logic [`HYPOT_IN_W-1:0]  y,
    input  hypot_pkg::sq_op_e       sq_op,
    output logic [`HYPOT_SUM_W-1:0] sum
);

    localparam int IN_W   = `HYPOT_IN_W;
    localparam int SUM_W  = `HYPOT_SUM_W;
    localparam int MCND_W = 2 * IN_W; // Room for the full left shift

    logic [MCND_W-1:0] mcand;  // Shifts left
    logic [IN_W-1:0]   mplier; // Shifts right, low bit gates the add
    logic [IN_W-1:0]   y_q;    // Held for the second squaring

    // Accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum <= '0;
        end else begin
            case (sq_op)
                hypot_pkg::SQ_START_X: sum <= '0;
                hypot_pkg::SQ_STEP: begin
                    if (mplier[0]) sum <= sum + {{(SUM_W-MCND_W){1'b0}}, mcand};
                end
                default: sum <= sum; // START_Y keeps x^2
            endcase
        end
    end

    // Shifters and the stored y
    always_ff @(posedge clk) begin
        case (sq_op)
            hypot_pkg::SQ_START_X: begin
                mcand  <= {{(MCND_W-IN_W){1'b0}}, x};
                mplier <= x;
                y_q    <= y;
            end
            hypot_pkg::SQ_START_Y: begin
                mcand  <= {{(MCND_W-IN_W){1'b0}}, y_q};
                mplier <= y_q;
            end
            hypot_pkg::SQ_STEP: begin
                mcand  <= {mcand[MCND_W-2:0], 1'b0};
                mplier <= {1'b0, mplier[IN_W-1:1]};
            end
            default: begin
                mcand  <= mcand;
                mplier <= mplier;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/step_counter.sv */
`default_nettype none
`timescale 1ns/1ns
`include "hypot_consts.svh"

module step_counter (
    input  logic                    clk,
    input  logic                    rst_n,
    input  hypot_pkg::hypot_state_e state,
    input  logic                    cnt_load,
    output logic                    last_step
);

    localparam int CNT_W = 4;

    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] load_len;

    // The load comes one cycle ahead, so map the current state to the phase being entered
    always_comb begin
        case (state)
            hypot_pkg::ST_LOAD_ROOT: load_len = CNT_W'(`HYPOT_ROOT_STEPS);
            default:                 load_len = CNT_W'(`HYPOT_SQ_STEPS); // From IDLE or LOAD_Y
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (cnt_load) begin
            count <= load_len;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign last_step = (count == CNT_W'(1)); // Final step is being issued

endmodule

`default_nettype wire

/* test/hypot_tb.sv */
`default_nettype none
`timescale 1ns/1ns
`include "hypot_consts.svh"

module hypot_tb;

    localparam int TIMEOUT  = `HYPOT_LATENCY + 10; // Edges allowed per wait
    localparam int N_RANDOM = 200;

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    logic [`HYPOT_IN_W-1:0] x;
    logic [`HYPOT_IN_W-1:0] y;
    logic [`HYPOT_IN_W-1:0] result;
    logic                   busy;
    logic                   done;

    logic [31:0]            lfsr_state;
    logic                   in_flight;  // An accepted operation is running
    int                     lat_cnt;    // Edges since the accepting edge
    logic [`HYPOT_IN_W-1:0] exp_result;
    int                     check_errs;
    int                     timeout_errs;
    int                     ops;

    hypot_top dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (start),
        .x      (x),
        .y      (y),
        .result (result),
        .busy   (busy),
        .done   (done)
    );

    always #10 clk = ~clk;

    // floor(sqrt(a^2 + b^2)), clamped to 8 bits
    function automatic logic [7:0] hypot_model(input logic [7:0] a, input logic [7:0] b);
        int sq;
        int r;
        sq = int'(a) * int'(a) + int'(b) * int'(b);
        r  = 0;
        while ((r + 1) * (r + 1) <= sq) r++;
        if (r > 255) r = 255;
        return r[7:0];
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_byte(output logic [7:0] v);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[6:0], lfsr_state[0]}; // One new bit per step
        end
    endtask

    // Follows acceptance and latency, latches the expected value
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_flight  <= 1'b0;
            lat_cnt    <= 0;
            exp_result <= '0;
        end else if (start && !busy) begin
            in_flight  <= 1'b1;
            lat_cnt    <= 0;
            exp_result <= hypot_model(x, y); // Operands as sampled at acceptance
        end else if (in_flight) begin
            if (lat_cnt == `HYPOT_LATENCY) in_flight <= 1'b0;
            else                           lat_cnt   <= lat_cnt + 1;
        end
    end

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (result == exp_result))
    else begin
        check_errs++;
        $display("Fail result: got %h, expected %h", $sampled(result), $sampled(exp_result));
    end

    a_done_early: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> (in_flight && lat_cnt == `HYPOT_LATENCY))
    else begin
        check_errs++;
        $display("Fail done: got %h, expected %h at edge %0d after start",
                 $sampled(done), 1'b0, $sampled(lat_cnt));
    end

    a_done_late: assert property (@(posedge clk) disable iff (!rst_n)
        (in_flight && lat_cnt == `HYPOT_LATENCY) |-> done)
    else begin
        check_errs++;
        $display("Fail done: got %h, expected %h", $sampled(done), 1'b1);
    end

    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
    else begin
        check_errs++;
        $display("Fail done: got %h, expected %h after pulse", $sampled(done), 1'b0);
    end

    a_busy_run: assert property (@(posedge clk) disable iff (!rst_n)
        (in_flight && lat_cnt < `HYPOT_LATENCY) |-> busy)
    else begin
        check_errs++;
        $display("Fail busy: got %h, expected %h", $sampled(busy), 1'b1);
    end

    a_busy_done: assert property (@(posedge clk) disable iff (!rst_n)
        done |-> !busy)
    else begin
        check_errs++;
        $display("Fail busy: got %h, expected %h with done", $sampled(busy), 1'b0);
    end

    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !in_flight |-> (!busy && !done))
    else begin
        check_errs++;
        $display("Fail busy/done: got %h/%h, expected 0/0 while idle",
                 $sampled(busy), $sampled(done));
    end

    // Result only moves together with done
    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !$stable(result) |-> done)
    else begin
        check_errs++;
        $display("Fail result: changed to %h without done", $sampled(result));
    end

    // One operation; disturb pulses start mid-run and scrambles x and y
    task automatic run_op(input logic [7:0] a, input logic [7:0] b, input bit disturb);
        int n;
        x     = a;
        y     = b;
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        if (disturb) begin
            draw_byte(x);
            draw_byte(y);
        end
        n = 0;
        while (!done && n < TIMEOUT) begin
            @(posedge clk);
            #2;
            start = (disturb && n == 5); // Dropped by the busy unit
            n++;
        end
        start = 1'b0;
        if (!done) begin
            timeout_errs++;
            $display("Timeout: no done within %0d cycles for x=%h y=%h", TIMEOUT, a, b);
        end
        ops++;
    endtask

    initial begin
        logic [7:0] a;
        logic [7:0] b;
        clk          = 1'b0;
        rst_n        = 1'b0;
        start        = 1'b0;
        x            = '0;
        y            = '0;
        lfsr_state   = 32'h58e0_28c5;
        check_errs   = 0;
        timeout_errs = 0;
        ops          = 0;

        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        assert (busy == 1'b0) else begin
            check_errs++;
            $display("Fail busy after reset: got %h, expected %h", busy, 1'b0);
        end
        assert (done == 1'b0) else begin
            check_errs++;
            $display("Fail done after reset: got %h, expected %h", done, 1'b0);
        end
        assert (result == '0) else begin
            check_errs++;
            $display("Fail result after reset: got %h, expected %h", result, 8'h00);
        end

        @(posedge clk);
        #2;

        // Corners, the last one saturates
        run_op(8'd0,   8'd0,   1'b0);
        run_op(8'd3,   8'd4,   1'b0);
        run_op(8'd255, 8'd0,   1'b0);
        run_op(8'd180, 8'd180, 1'b1);
        run_op(8'd255, 8'd255, 1'b0);

        for (int i = 0; i < N_RANDOM; i++) begin
            draw_byte(a);
            draw_byte(b);
            run_op(a, b, (i % 4) == 3);
        end

        repeat (3) @(posedge clk); // Let the last done be sampled

        $display("Operations: %0d, check errors: %0d, timeouts: %0d",
                 ops, check_errs, timeout_errs);
        if (check_errs == 0 && timeout_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
